// File: design/raster_pkg.sv
// fixed-point formats shared by the front end; camera and normal vectors are Q1.14, colors RGB565
package raster_pkg;

  // fractional bits of camera basis vectors and face normals
  localparam int FRAC_BITS = 14;

  // signed widths of the 3D inputs
  localparam int P_WIDTH = 16;  // vertex coordinates
  localparam int C_WIDTH = 18;  // camera position
  localparam int V_WIDTH = 16;  // unit vectors

  // unsigned depth
  localparam int ZWIDTH = 16;

  // signed viewport coordinates
  localparam int VX_WIDTH = 18;
  localparam int VY_WIDTH = 20;

  localparam int COLOR_WIDTH = 16;

  // brightness factor, 0 means darkest, max leaves the color unchanged
  localparam int BRIGHT_BITS = 4;
  localparam int BRIGHT_MAX = (1 << BRIGHT_BITS) - 1;

  // one RGB565 word, moved around as raw and scaled per channel
  typedef union packed {
    logic [COLOR_WIDTH-1:0] raw;
    struct packed {
      logic [4:0] r;
      logic [5:0] g;
      logic [4:0] b;
    } rgb;
  } color_u;

endpackage

// File: design/camera_regs.sv
// camera registers have no reset value, so a camera must be loaded before the first triangle
`timescale 1ns/100ps

module camera_regs import raster_pkg::*; (
  input  logic clk_in,
  input  logic rst_in,

  input  logic cam_valid,
  output logic cam_ready,
  input  logic signed [2:0][C_WIDTH-1:0] cam_c_in,
  input  logic signed [2:0][V_WIDTH-1:0] cam_u_in,
  input  logic signed [2:0][V_WIDTH-1:0] cam_v_in,
  input  logic signed [2:0][V_WIDTH-1:0] cam_n_in,

  output logic signed [2:0][C_WIDTH-1:0] cam_c,
  output logic signed [2:0][V_WIDTH-1:0] cam_u,
  output logic signed [2:0][V_WIDTH-1:0] cam_v,
  output logic signed [2:0][V_WIDTH-1:0] cam_n
);

  logic busy;  // high for the cycle after a load

  assign cam_ready = !busy;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= 1'b0;
    end else begin
      busy <= cam_valid && cam_ready;
    end
  end

  always_ff @(posedge clk_in) begin
    if (cam_valid && cam_ready) begin
      cam_c <= cam_c_in;
      cam_u <= cam_u_in;
      cam_v <= cam_v_in;
      cam_n <= cam_n_in;
    end
  end

  // a pending camera must be held until it is taken
  a_cam_hold: assert property (@(posedge clk_in) disable iff (rst_in)
    cam_valid && !cam_ready |=> cam_valid && $stable({cam_c_in, cam_u_in, cam_v_in, cam_n_in}))
    else $error("camera request changed before transfer");

endmodule

// File: design/vertex_pre_proc.sv
// orthographic only, no clipping; assumes P_WIDTH <= C_WIDTH and truncates results to port widths
`timescale 1ns/100ps

module vertex_pre_proc import raster_pkg::*; #(
  parameter int VW_OVER_TWO = 160,
  parameter int VH_OVER_TWO = 120
) (
  input  logic clk_in,
  input  logic rst_in,
  input  logic start,

  input  logic signed [2:0][2:0][P_WIDTH-1:0] tri_p,  // [vertex][x,y,z]
  input  logic signed [2:0][C_WIDTH-1:0] cam_c,
  input  logic signed [2:0][V_WIDTH-1:0] cam_u,
  input  logic signed [2:0][V_WIDTH-1:0] cam_v,
  input  logic signed [2:0][V_WIDTH-1:0] cam_n,

  output logic done,
  output logic cull,
  output logic signed [2:0][VX_WIDTH-1:0] vx,
  output logic signed [2:0][VY_WIDTH-1:0] vy,
  output logic [2:0][ZWIDTH-1:0] vz
);

  localparam int D_W = C_WIDTH + 1;  // P - C
  localparam int M_W = D_W + V_WIDTH;  // one product
  localparam int S_W = M_W + 2;  // sum of three

  logic s1_valid, s2_valid;

  // stage 1: offsets from the camera plus the basis used for this triangle
  logic signed [D_W-1:0] d1 [3][3];
  logic signed [2:0][V_WIDTH-1:0] bu, bv, bn;

  // stage 2: products per vertex and axis
  logic signed [M_W-1:0] mu [3][3];
  logic signed [M_W-1:0] mv [3][3];
  logic signed [M_W-1:0] mn [3][3];

  // stage 3 sums, combinational
  logic signed [S_W-1:0] pu [3];
  logic signed [S_W-1:0] pv [3];
  logic signed [S_W-1:0] pz [3];
  logic signed [S_W-1:0] xf [3];
  logic signed [S_W-1:0] yf [3];
  logic behind;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      done <= 1'b0;
      cull <= 1'b0;
    end else begin
      s1_valid <= start;
      s2_valid <= s1_valid;
      done <= s2_valid;
      cull <= s2_valid && behind;
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin  // basis sampled once so a camera reload cannot split a triangle
      bu <= cam_u;
      bv <= cam_v;
      bn <= cam_n;
      for (int i = 0; i < 3; i++) begin
        for (int j = 0; j < 3; j++) begin
          d1[i][j] <= $signed(tri_p[i][j]) - $signed(cam_c[j]);
        end
      end
    end
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        mu[i][j] <= d1[i][j] * $signed(bu[j]);
        mv[i][j] <= d1[i][j] * $signed(bv[j]);
        mn[i][j] <= d1[i][j] * $signed(bn[j]);
      end
    end
    for (int i = 0; i < 3; i++) begin
      vx[i] <= xf[i][VX_WIDTH-1:0];
      vy[i] <= yf[i][VY_WIDTH-1:0];
      vz[i] <= pz[i][ZWIDTH-1:0];
    end
  end

  always_comb begin
    behind = 1'b0;
    for (int i = 0; i < 3; i++) begin
      pu[i] = (mu[i][0] + mu[i][1] + mu[i][2]) >>> FRAC_BITS;
      pv[i] = (mv[i][0] + mv[i][1] + mv[i][2]) >>> FRAC_BITS;
      pz[i] = (mn[i][0] + mn[i][1] + mn[i][2]) >>> FRAC_BITS;
      xf[i] = pu[i] + VW_OVER_TWO;  // shift origin to viewport center
      yf[i] = pv[i] + VH_OVER_TWO;
      if (pz[i] <= 0) begin
        behind = 1'b1;  // at or behind the camera plane
      end
    end
  end

endmodule

// File: design/shader.sv
// flat shading from a per-triangle table; attribute writes must not coincide with a start
`timescale 1ns/100ps

module shader import raster_pkg::*; #(
  parameter int NUM_TRI = 64
) (
  input  logic clk_in,
  input  logic rst_in,
  input  logic start,
  input  logic [$clog2(NUM_TRI)-1:0] tri_id,
  input  logic signed [2:0][V_WIDTH-1:0] cam_n,

  input  logic attr_we,
  input  logic [$clog2(NUM_TRI)-1:0] attr_id,
  input  logic signed [2:0][V_WIDTH-1:0] attr_normal,
  input  logic [COLOR_WIDTH-1:0] attr_color,

  output logic done,
  output logic cull,
  output color_u color
);

  localparam int DOT_W = 2 * V_WIDTH + 2;

  logic signed [2:0][V_WIDTH-1:0] nrm_mem [NUM_TRI];
  logic [COLOR_WIDTH-1:0] col_mem [NUM_TRI];

  logic s1_valid, s2_valid;
  logic signed [2:0][V_WIDTH-1:0] nrm_s1, camn_s1;
  color_u col_s1, col_s2;
  logic away_s2;
  logic [BRIGHT_BITS-1:0] bright_s2;

  logic signed [DOT_W-1:0] s;
  logic [DOT_W-1:0] lum;  // -s scaled down to the brightness range
  logic [BRIGHT_BITS-1:0] bright;
  logic [BRIGHT_BITS:0] gain;
  logic [9:0] r_prod;
  logic [10:0] g_prod;
  logic [9:0] b_prod;
  color_u scaled;

  always_ff @(posedge clk_in) begin
    if (attr_we) begin
      nrm_mem[attr_id] <= attr_normal;
      col_mem[attr_id] <= attr_color;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      done <= 1'b0;
      cull <= 1'b0;
    end else begin
      s1_valid <= start;
      s2_valid <= s1_valid;
      done <= s2_valid;
      cull <= s2_valid && away_s2;
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin
      nrm_s1 <= nrm_mem[tri_id];
      col_s1 <= col_mem[tri_id];
      camn_s1 <= cam_n;
    end
    away_s2 <= (s >= 0);
    bright_s2 <= bright;
    col_s2 <= col_s1;
    color <= scaled;
  end

  // facing test and brightness from the stage 1 registers
  always_comb begin
    s = ($signed(nrm_s1[0]) * $signed(camn_s1[0])
       + $signed(nrm_s1[1]) * $signed(camn_s1[1])
       + $signed(nrm_s1[2]) * $signed(camn_s1[2])) >>> FRAC_BITS;
    lum = DOT_W'(-s) >> (FRAC_BITS - BRIGHT_BITS);  // meaningless when culled
    if (lum > BRIGHT_MAX) begin
      bright = BRIGHT_MAX[BRIGHT_BITS-1:0];
    end else begin
      bright = lum[BRIGHT_BITS-1:0];
    end
  end

  // channel * (b + 1) / 16, full brightness keeps the base color
  always_comb begin
    gain = {1'b0, bright_s2} + 1'b1;
    r_prod = col_s2.rgb.r * gain;
    g_prod = col_s2.rgb.g * gain;
    b_prod = col_s2.rgb.b * gain;
    scaled.rgb.r = 5'(r_prod >> BRIGHT_BITS);
    scaled.rgb.g = 6'(g_prod >> BRIGHT_BITS);
    scaled.rgb.b = 5'(b_prod >> BRIGHT_BITS);
  end

  // table writes while a lookup starts would race the read
  a_no_write_on_start: assert property (@(posedge clk_in) disable iff (rst_in)
    start |-> !attr_we)
    else $error("attribute write during shader start");

endmodule

// File: design/pre_proc_shader.sv
// one triangle in flight at a time; both units are expected to answer once per start
`timescale 1ns/100ps

module pre_proc_shader import raster_pkg::*; #(
  parameter int NUM_TRI = 64
) (
  input  logic clk_in,
  input  logic rst_in,

  input  logic tri_valid,
  output logic tri_ready,
  input  logic [$clog2(NUM_TRI)-1:0] tri_id_in,
  input  logic signed [2:0][2:0][P_WIDTH-1:0] tri_p_in,

  input  logic vpp_done,
  input  logic vpp_cull,
  input  logic signed [2:0][VX_WIDTH-1:0] vx,
  input  logic signed [2:0][VY_WIDTH-1:0] vy,
  input  logic [2:0][ZWIDTH-1:0] vz,
  input  logic sh_done,
  input  logic sh_cull,
  input  logic [COLOR_WIDTH-1:0] color,

  output logic start,
  output logic [$clog2(NUM_TRI)-1:0] tri_id,
  output logic signed [2:0][2:0][P_WIDTH-1:0] tri_p,

  output logic push,
  input  logic full,
  output logic signed [2:0][VX_WIDTH-1:0] out_vx,
  output logic signed [2:0][VY_WIDTH-1:0] out_vy,
  output logic [2:0][ZWIDTH-1:0] out_z,
  output logic [COLOR_WIDTH-1:0] out_color,
  output logic [15:0] culled_count
);

  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] PROCESSING = 2'd1;
  localparam logic [1:0] HOLD = 2'd2;

  logic [1:0] state;
  logic vpp_got, sh_got;  // result already latched
  logic sent;  // primitive handed to the FIFO
  logic any_cull;
  logic both_in;

  assign tri_ready = (state == IDLE);
  assign any_cull = (vpp_done && vpp_cull) || (sh_done && sh_cull);
  assign both_in = (vpp_got || vpp_done) && (sh_got || sh_done);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      start <= 1'b0;
      push <= 1'b0;
      sent <= 1'b0;
      vpp_got <= 1'b0;
      sh_got <= 1'b0;
      culled_count <= '0;
    end else begin
      case (state)
        IDLE: begin
          vpp_got <= 1'b0;
          sh_got <= 1'b0;
          if (tri_valid) begin
            start <= 1'b1;  // launch both units together
            state <= PROCESSING;
          end
        end

        PROCESSING: begin
          start <= 1'b0;
          if (vpp_done) vpp_got <= 1'b1;
          if (sh_done) sh_got <= 1'b1;
          if (any_cull) begin
            culled_count <= culled_count + 16'd1;
            state <= IDLE;
          end else if (both_in) begin
            push <= !full;
            state <= HOLD;
          end
        end

        HOLD: begin
          if (push) begin
            push <= 1'b0;
            sent <= 1'b1;
          end else if (sent) begin
            sent <= 1'b0;
            state <= IDLE;
          end else if (!full) begin
            push <= 1'b1;  // space freed by the reader
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  // payload captures
  always_ff @(posedge clk_in) begin
    if (state == IDLE && tri_valid) begin
      tri_id <= tri_id_in;
      tri_p <= tri_p_in;
    end
    if (state == PROCESSING && vpp_done) begin
      out_vx <= vx;
      out_vy <= vy;
      out_z <= vz;
    end
    if (state == PROCESSING && sh_done) begin
      out_color <= color;
    end
  end

  // a new launch must not overlap answers still due from the previous triangle
  a_start_from_idle: assert property (@(posedge clk_in) disable iff (rst_in)
    start |-> $past(state == IDLE) && !vpp_done && !sh_done)
    else $error("unit start outside IDLE or while a unit was still answering");

endmodule

// File: design/prim_fifo.sv
// primitives are stored whole; writer must never push while full
`timescale 1ns/100ps

module prim_fifo import raster_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic clk_in,
  input  logic rst_in,

  input  logic push,
  output logic full,
  input  logic signed [2:0][VX_WIDTH-1:0] in_vx,
  input  logic signed [2:0][VY_WIDTH-1:0] in_vy,
  input  logic [2:0][ZWIDTH-1:0] in_z,
  input  logic [COLOR_WIDTH-1:0] in_color,

  output logic prim_valid,
  input  logic prim_ready,
  output logic signed [2:0][VX_WIDTH-1:0] prim_vx,
  output logic signed [2:0][VY_WIDTH-1:0] prim_vy,
  output logic [2:0][ZWIDTH-1:0] prim_z,
  output logic [COLOR_WIDTH-1:0] prim_color
);

  localparam int E_W = 3 * (VX_WIDTH + VY_WIDTH + ZWIDTH) + COLOR_WIDTH;
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [E_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic pop;

  assign full = (count == CNT_W'(FIFO_DEPTH));
  assign prim_valid = (count != '0);
  assign pop = prim_valid && prim_ready;
  assign {prim_vx, prim_vy, prim_z, prim_color} = mem[rd_ptr];

  always_ff @(posedge clk_in) begin
    if (push) mem[wr_ptr] <= {in_vx, in_vy, in_z, in_color};
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  a_no_overflow: assert property (@(posedge clk_in) disable iff (rst_in)
    push |-> !full)
    else $error("primitive pushed into a full FIFO");

endmodule

// File: design/raster_front_end.sv
// orthographic triangle front end; load a camera first and keep attribute writes off start cycles
`timescale 1ns/100ps

module raster_front_end import raster_pkg::*; #(
  parameter int NUM_TRI = 64,
  parameter int FIFO_DEPTH = 4,
  parameter int VW_OVER_TWO = 160,
  parameter int VH_OVER_TWO = 120
) (
  input  logic clk_in,
  input  logic rst_in,

  input  logic cam_valid,
  output logic cam_ready,
  input  logic signed [2:0][C_WIDTH-1:0] cam_c_in,
  input  logic signed [2:0][V_WIDTH-1:0] cam_u_in,
  input  logic signed [2:0][V_WIDTH-1:0] cam_v_in,
  input  logic signed [2:0][V_WIDTH-1:0] cam_n_in,

  input  logic attr_we,
  input  logic [$clog2(NUM_TRI)-1:0] attr_id,
  input  logic signed [2:0][V_WIDTH-1:0] attr_normal,
  input  logic [COLOR_WIDTH-1:0] attr_color,

  input  logic tri_valid,
  output logic tri_ready,
  input  logic [$clog2(NUM_TRI)-1:0] tri_id,
  input  logic signed [2:0][2:0][P_WIDTH-1:0] tri_p,

  output logic prim_valid,
  input  logic prim_ready,
  output logic signed [2:0][VX_WIDTH-1:0] prim_vx,
  output logic signed [2:0][VY_WIDTH-1:0] prim_vy,
  output logic [2:0][ZWIDTH-1:0] prim_z,
  output logic [COLOR_WIDTH-1:0] prim_color,
  output logic [15:0] culled_count
);

  logic signed [2:0][C_WIDTH-1:0] cam_c;
  logic signed [2:0][V_WIDTH-1:0] cam_u, cam_v, cam_n;
  logic start;
  logic [$clog2(NUM_TRI)-1:0] lat_tri_id;
  logic signed [2:0][2:0][P_WIDTH-1:0] lat_tri_p;
  logic vpp_done, vpp_cull, sh_done, sh_cull;
  logic signed [2:0][VX_WIDTH-1:0] vpp_vx, cmb_vx;
  logic signed [2:0][VY_WIDTH-1:0] vpp_vy, cmb_vy;
  logic [2:0][ZWIDTH-1:0] vpp_vz, cmb_z;
  color_u sh_color;
  logic [COLOR_WIDTH-1:0] cmb_color;
  logic push, full;

  camera_regs i_camera_regs (
    .clk_in, .rst_in, .cam_valid, .cam_ready,
    .cam_c_in, .cam_u_in, .cam_v_in, .cam_n_in,
    .cam_c, .cam_u, .cam_v, .cam_n
  );

  pre_proc_shader #(.NUM_TRI(NUM_TRI)) i_pre_proc_shader (
    .clk_in, .rst_in, .tri_valid, .tri_ready,
    .tri_id_in(tri_id), .tri_p_in(tri_p),
    .vpp_done, .vpp_cull, .vx(vpp_vx), .vy(vpp_vy), .vz(vpp_vz),
    .sh_done, .sh_cull, .color(sh_color.raw),
    .start, .tri_id(lat_tri_id), .tri_p(lat_tri_p),
    .push, .full,
    .out_vx(cmb_vx), .out_vy(cmb_vy), .out_z(cmb_z), .out_color(cmb_color),
    .culled_count
  );

  vertex_pre_proc #(.VW_OVER_TWO(VW_OVER_TWO), .VH_OVER_TWO(VH_OVER_TWO)) i_vertex_pre_proc (
    .clk_in, .rst_in, .start, .tri_p(lat_tri_p),
    .cam_c, .cam_u, .cam_v, .cam_n,
    .done(vpp_done), .cull(vpp_cull), .vx(vpp_vx), .vy(vpp_vy), .vz(vpp_vz)
  );

  shader #(.NUM_TRI(NUM_TRI)) i_shader (
    .clk_in, .rst_in, .start, .tri_id(lat_tri_id), .cam_n,
    .attr_we, .attr_id, .attr_normal, .attr_color,
    .done(sh_done), .cull(sh_cull), .color(sh_color)
  );

  prim_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_prim_fifo (
    .clk_in, .rst_in, .push, .full,
    .in_vx(cmb_vx), .in_vy(cmb_vy), .in_z(cmb_z), .in_color(cmb_color),
    .prim_valid, .prim_ready, .prim_vx, .prim_vy, .prim_z, .prim_color
  );

endmodule

// File: tests/raster_front_end_tb.sv
// self-checking testbench; table values assume the default viewport, run bounded by a watchdog
`timescale 1ns/100ps

module raster_front_end_tb import raster_pkg::*; ();

  localparam int NUM_TRI = 64;
  localparam int FIFO_DEPTH = 4;
  localparam int VW_OVER_TWO = 160;
  localparam int VH_OVER_TWO = 120;
  localparam int ID_W = $clog2(NUM_TRI);
  localparam int NUM_ENTRIES = 12;
  localparam int BP_COUNT = FIFO_DEPTH + 2;  // FIFO full plus one in the combiner and one waiting
  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int WATCHDOG_CYCLES = (NUM_ENTRIES + BP_COUNT) * 20 + 200;

  logic clk_in, rst_in;
  logic cam_valid, cam_ready;
  logic signed [2:0][C_WIDTH-1:0] cam_c_in;
  logic signed [2:0][V_WIDTH-1:0] cam_u_in, cam_v_in, cam_n_in;
  logic attr_we;
  logic [ID_W-1:0] attr_id;
  logic signed [2:0][V_WIDTH-1:0] attr_normal;
  logic [COLOR_WIDTH-1:0] attr_color;
  logic tri_valid, tri_ready;
  logic [ID_W-1:0] tri_id;
  logic signed [2:0][2:0][P_WIDTH-1:0] tri_p;
  logic prim_valid, prim_ready;
  logic signed [2:0][VX_WIDTH-1:0] prim_vx;
  logic signed [2:0][VY_WIDTH-1:0] prim_vy;
  logic [2:0][ZWIDTH-1:0] prim_z;
  logic [COLOR_WIDTH-1:0] prim_color;
  logic [15:0] culled_count;

  // stimulus table indexed by triangle id
  string t_name [NUM_ENTRIES];
  int t_cam [NUM_ENTRIES];
  logic signed [2:0][2:0][P_WIDTH-1:0] t_p [NUM_ENTRIES];
  logic signed [2:0][V_WIDTH-1:0] t_nrm [NUM_ENTRIES];
  logic [COLOR_WIDTH-1:0] t_col [NUM_ENTRIES];
  bit t_drawn [NUM_ENTRIES];

  logic signed [2:0][C_WIDTH-1:0] cam_c_tab [2];
  logic signed [2:0][V_WIDTH-1:0] cam_u_tab [2], cam_v_tab [2], cam_n_tab [2];

  // primitives still owed by the DUT with the oldest first
  logic [63:0] q_vx [$], q_vy [$], q_z [$], q_col [$];
  string q_name [$];
  int exp_culled, n_expected, n_received, cur_cam;
  integer seed;

  raster_front_end #(
    .NUM_TRI(NUM_TRI), .FIFO_DEPTH(FIFO_DEPTH),
    .VW_OVER_TWO(VW_OVER_TWO), .VH_OVER_TWO(VH_OVER_TWO)
  ) i_raster_front_end (.*);

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    assert (act_v === exp_v)
      else report_failure($sformatf("error %s %s: expected %h, actual %h",
                                    name, what, exp_v, act_v));
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("timeout: the test did not reach its end in time");
  end

  task automatic place_vertex(input int e, input int i, input int x, input int y, input int z);
    t_p[e][i][0] = 16'(x);
    t_p[e][i][1] = 16'(y);
    t_p[e][i][2] = 16'(z);
  endtask

  // triangle (x,y,z) (x+w,y,z) (x,y+w,z+dz)
  task automatic set_entry(input int e, input string name, input int cam, input int x,
                           input int y, input int z, input int w, input int dz, input int nx,
                           input int ny, input int nz, input logic [15:0] col, input bit drawn);
    t_name[e] = name;
    t_cam[e] = cam;
    t_col[e] = col;
    t_drawn[e] = drawn;
    t_nrm[e][0] = 16'(nx);
    t_nrm[e][1] = 16'(ny);
    t_nrm[e][2] = 16'(nz);
    place_vertex(e, 0, x, y, z);
    place_vertex(e, 1, x + w, y, z);
    place_vertex(e, 2, x, y + w, z + dz);
  endtask

  task automatic randomize_vertices(input int e);
    int rx, ry, rz;
    for (int i = 0; i < 3; i++) begin
      rx = $random(seed) % 1500;
      ry = $random(seed) % 1500;
      rz = 100 + int'({$random(seed)} % 1500);  // stays in front of both cameras
      place_vertex(e, i, rx, ry, rz);
    end
  endtask

  task automatic build_table();
    cam_c_tab[0] = {-18'sd1000, 18'sd0, 18'sd0};  // axis aligned and looking down +z
    cam_u_tab[0] = {16'sd0, 16'sd0, 16'sd16384};
    cam_v_tab[0] = {16'sd0, 16'sd16384, 16'sd0};
    cam_n_tab[0] = {16'sd16384, 16'sd0, 16'sd0};
    cam_c_tab[1] = {-18'sd600, -18'sd100, 18'sd200};  // rotated 45 degrees about z
    cam_u_tab[1] = {16'sd0, 16'sd11585, 16'sd11585};
    cam_v_tab[1] = {16'sd0, 16'sd11585, -16'sd11585};
    cam_n_tab[1] = {16'sd16384, 16'sd0, 16'sd0};
    set_entry(0, "front_flat", 0, 0, 0, 0, 100, 0, 0, 0, -16384, 16'hf81f, 1'b1);
    set_entry(1, "front_half", 0, -150, -100, 50, 60, 400, 0, 0, -8192, 16'hffff, 1'b1);
    set_entry(2, "front_dim", 0, 300, -200, 10, 25, 5, 8000, 0, -3000, 16'h7bef, 1'b1);
    set_entry(3, "vertex_behind", 0, 10, 10, 100, 50, -1300, 0, 0, -16384, 16'h07e0, 1'b0);
    set_entry(4, "vertex_on_plane", 0, 10, 10, 50, 50, -1050, 0, 0, -16384, 16'h001f, 1'b0);
    set_entry(5, "back_face", 0, 0, 0, 0, 80, 0, 0, 0, 16384, 16'hf800, 1'b0);
    set_entry(6, "edge_on", 0, 20, 20, 20, 40, 0, 16384, 0, 0, 16'h0841, 1'b0);
    set_entry(7, "random_a", 0, 0, 0, 0, 0, 0, 0, -4096, -12000, 16'h1234, 1'b1);
    set_entry(8, "random_b", 0, 0, 0, 0, 0, 0, 0, 0, -16384, 16'habcd, 1'b1);
    set_entry(9, "cam1_front", 1, 50, 75, 0, 120, 30, 0, 0, -16384, 16'h5555, 1'b1);
    set_entry(10, "cam1_random", 1, 0, 0, 0, 0, 0, -6000, 2000, -15000, 16'hc3a7, 1'b1);
    set_entry(11, "cam1_back", 1, 0, 0, 0, 10, 0, 0, 3000, 100, 16'h39e7, 1'b0);
    randomize_vertices(7);
    randomize_vertices(8);
    randomize_vertices(10);
  endtask

  // orthographic projection and flat shading model
  task automatic predict(input int e, input int c, output bit drawn, output logic [63:0] vx,
                         output logic [63:0] vy, output logic [63:0] vz, output logic [63:0] col);
    longint d, su, sv, sn, s, tx, ty;
    int bright, r, g, b;
    bit behind;
    behind = 1'b0;
    vx = '0;
    vy = '0;
    vz = '0;
    for (int i = 0; i < 3; i++) begin
      su = 0;
      sv = 0;
      sn = 0;
      for (int j = 0; j < 3; j++) begin
        d = longint'($signed(t_p[e][i][j])) - longint'($signed(cam_c_tab[c][j]));
        su += d * longint'($signed(cam_u_tab[c][j]));
        sv += d * longint'($signed(cam_v_tab[c][j]));
        sn += d * longint'($signed(cam_n_tab[c][j]));
      end
      tx = (su >>> FRAC_BITS) + VW_OVER_TWO;
      ty = (sv >>> FRAC_BITS) + VH_OVER_TWO;
      sn = sn >>> FRAC_BITS;
      vx[i*VX_WIDTH +: VX_WIDTH] = tx[VX_WIDTH-1:0];
      vy[i*VY_WIDTH +: VY_WIDTH] = ty[VY_WIDTH-1:0];
      vz[i*ZWIDTH +: ZWIDTH] = sn[ZWIDTH-1:0];
      if (sn <= 0) begin
        behind = 1'b1;
      end
    end
    s = 0;
    for (int j = 0; j < 3; j++) begin
      s += longint'($signed(t_nrm[e][j])) * longint'($signed(cam_n_tab[c][j]));
    end
    s = s >>> FRAC_BITS;
    bright = (s < 0) ? int'((-s) >>> (FRAC_BITS - 4)) : 0;
    if (bright > 15) begin
      bright = 15;
    end
    r = (int'(t_col[e][15:11]) * (bright + 1)) >> 4;  // RGB565 channels
    g = (int'(t_col[e][10:5]) * (bright + 1)) >> 4;
    b = (int'(t_col[e][4:0]) * (bright + 1)) >> 4;
    col = {48'd0, r[4:0], g[5:0], b[4:0]};
    drawn = !behind && (s < 0);
  endtask

  task automatic drive_tri(input int e, input bit check_class);
    bit drawn;
    logic [63:0] vx, vy, vz, col;
    predict(e, cur_cam, drawn, vx, vy, vz, col);
    if (check_class) begin
      assert (drawn == t_drawn[e])
        else report_failure($sformatf("table entry %s disagrees with the model", t_name[e]));
    end
    if (drawn) begin
      q_vx.push_back(vx);
      q_vy.push_back(vy);
      q_z.push_back(vz);
      q_col.push_back(col);
      q_name.push_back(t_name[e]);
      n_expected++;
    end else begin
      exp_culled++;
    end
    tri_id = ID_W'(e);
    tri_p = t_p[e];
    tri_valid = 1'b1;
  endtask

  task automatic wait_accept();
    @(negedge clk_in);
    while (!tri_ready) @(negedge clk_in);
    @(posedge clk_in);
    #DRIVE_DELAY;
    tri_valid = 1'b0;
  endtask

  task automatic wait_idle();
    @(negedge clk_in);
    while (!tri_ready) @(negedge clk_in);
    @(posedge clk_in);
    #DRIVE_DELAY;
  endtask

  task automatic wait_drained();
    while (n_received != n_expected) @(posedge clk_in);
    #DRIVE_DELAY;
  endtask

  task automatic load_camera(input int c);
    cam_c_in = cam_c_tab[c];
    cam_u_in = cam_u_tab[c];
    cam_v_in = cam_v_tab[c];
    cam_n_in = cam_n_tab[c];
    cam_valid = 1'b1;
    @(negedge clk_in);
    while (!cam_ready) @(negedge clk_in);
    @(posedge clk_in);
    #DRIVE_DELAY;
    cam_valid = 1'b0;
    cur_cam = c;
  endtask

  task automatic write_attributes();
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      attr_we = 1'b1;
      attr_id = ID_W'(e);
      attr_normal = t_nrm[e];
      attr_color = t_col[e];
      @(posedge clk_in);
      #DRIVE_DELAY;
    end
    attr_we = 1'b0;
  endtask

  function automatic int bp_entry(input int k);
    int list [$];
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      if (t_drawn[e]) begin
        list.push_back(e);
      end
    end
    return list[k % list.size()];
  endfunction

  // compare every primitive the FIFO hands out before its transfer edge
  always @(negedge clk_in) begin
    if (!rst_in && prim_valid && prim_ready) begin
      assert (q_name.size() > 0)
        else report_failure("a primitive left the FIFO when none was expected");
      check_value(q_name[0], "prim_vx", q_vx[0], 64'($unsigned(prim_vx)));
      check_value(q_name[0], "prim_vy", q_vy[0], 64'($unsigned(prim_vy)));
      check_value(q_name[0], "prim_z", q_z[0], 64'(prim_z));
      check_value(q_name[0], "prim_color", q_col[0], 64'(prim_color));
      void'(q_vx.pop_front());
      void'(q_vy.pop_front());
      void'(q_z.pop_front());
      void'(q_col.pop_front());
      void'(q_name.pop_front());
      n_received++;
    end
  end

  initial begin
    rst_in = 1'b1;
    cam_valid = 1'b0;
    cam_c_in = '0;
    cam_u_in = '0;
    cam_v_in = '0;
    cam_n_in = '0;
    attr_we = 1'b0;
    attr_id = '0;
    attr_normal = '0;
    attr_color = '0;
    tri_valid = 1'b0;
    tri_id = '0;
    tri_p = '0;
    prim_ready = 1'b1;
    seed = 32'hd576f087;
    exp_culled = 0;
    n_expected = 0;
    n_received = 0;
    cur_cam = -1;
    build_table();
    repeat (5) @(posedge clk_in);
    #DRIVE_DELAY;
    rst_in = 1'b0;
    @(negedge clk_in);
    check_value("reset", "tri_ready", 64'd1, 64'(tri_ready));
    check_value("reset", "cam_ready", 64'd1, 64'(cam_ready));
    check_value("reset", "prim_valid", 64'd0, 64'(prim_valid));
    check_value("reset", "culled_count", 64'd0, 64'(culled_count));
    @(posedge clk_in);
    #DRIVE_DELAY;
    write_attributes();

    // one triangle at a time with a camera swap where the table asks
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      if (t_cam[e] != cur_cam) begin
        load_camera(t_cam[e]);
      end
      drive_tri(e, 1'b1);
      wait_accept();
      wait_idle();
      check_value(t_name[e], "culled_count", 64'(exp_culled), 64'(culled_count));
    end

    // back-pressure from the output side
    wait_drained();
    prim_ready = 1'b0;
    for (int k = 0; k < BP_COUNT - 1; k++) begin
      drive_tri(bp_entry(k), 1'b0);
      wait_accept();
    end
    drive_tri(bp_entry(BP_COUNT - 1), 1'b0);
    repeat (20) begin
      @(negedge clk_in);
      assert (!tri_ready)
        else report_failure("tri_ready rose while the primitive FIFO was full");
    end
    check_value("backpressure", "prim_valid", 64'd1, 64'(prim_valid));
    @(posedge clk_in);
    #DRIVE_DELAY;
    prim_ready = 1'b1;
    wait_accept();
    wait_drained();

    check_value("final", "culled_count", 64'(exp_culled), 64'(culled_count));
    check_value("final", "prim_valid", 64'd0, 64'(prim_valid));
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: raster_front_end.f
design/raster_pkg.sv
design/camera_regs.sv
design/vertex_pre_proc.sv
design/shader.sv
design/pre_proc_shader.sv
design/prim_fifo.sv
design/raster_front_end.sv
tests/raster_front_end_tb.sv

// File: Makefile
# Verilator flow for the raster front end; every variable can be overridden on the command line

VERILATOR ?= verilator
FILELIST ?= raster_front_end.f
TOP ?= raster_front_end_tb
LINT_TOP ?= raster_front_end
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert
PASS_MSG ?= TEST PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the run passes only when the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
